//--- common/instrQueueIf.sv
`timescale 1ns/1ps
`default_nettype none

interface instrQueueIf;
    import rvPkg::*;

    logic            valid;
    logic            ready;
    logic [xlen-1:0] pc;
    instrWord        instr;
    // Drops every entry still on its way to execution
    logic            flush;

    modport producer (output valid, pc, instr, input ready, flush);

    modport queue (input valid, pc, instr, output ready, flush);

    modport consumer (input valid, pc, instr, output ready, flush);

endinterface

`default_nettype wire

//--- common/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int xlen = 32;

    // Major opcodes
    localparam logic [6:0] opRType  = 7'b0110011;
    localparam logic [6:0] opIType  = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [3:0] aluAdd   = 4'b0000;
    localparam logic [3:0] aluSub   = 4'b0001;
    localparam logic [3:0] aluXor   = 4'b0010;
    localparam logic [3:0] aluOr    = 4'b0011;
    localparam logic [3:0] aluAnd   = 4'b0100;
    localparam logic [3:0] aluSll   = 4'b0101;
    localparam logic [3:0] aluSrl   = 4'b0110;
    localparam logic [3:0] aluSra   = 4'b0111;
    localparam logic [3:0] aluSlt   = 4'b1000;
    localparam logic [3:0] aluSltu  = 4'b1001;
    localparam logic [3:0] aluPassB = 4'b1010;

    // Immediate formats
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immU = 3'b011;
    localparam logic [2:0] immJ = 3'b100;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instrWord;

endpackage

`default_nettype wire

//--- core/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  rvPkg::instrWord instr,
    input  logic            zero,
    input  logic            lessThan,
    output logic [2:0]      immSel,
    output logic [3:0]      aluCtrl,
    output logic            aluSrc,
    output logic            aluPcSelect,
    output logic            resultSel,
    output logic            regWrite,
    output logic            memRead,
    output logic            memWrite,
    output logic            unsignedCmp,
    output logic            jump,
    output logic            jumpReg,
    output logic            pcSrc
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7Alt;

    assign opcode    = instr.rType.opcode;
    assign funct3    = instr.rType.funct3;
    // Picks SUB over ADD and SRA over SRL
    assign funct7Alt = instr.rType.funct7[5];

    // BLTU and BGEU
    assign unsignedCmp = (opcode == opBranch) && funct3[1];

    always_comb begin
        immSel      = immI;
        aluCtrl     = aluAdd;
        aluSrc      = 1'b0;
        aluPcSelect = 1'b0;
        resultSel   = 1'b0;
        regWrite    = 1'b0;
        memRead     = 1'b0;
        memWrite    = 1'b0;
        jump        = 1'b0;
        jumpReg     = 1'b0;
        pcSrc       = 1'b0;

        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000: aluCtrl = funct7Alt ? aluSub : aluAdd;
                    3'b001: aluCtrl = aluSll;
                    3'b010: aluCtrl = aluSlt;
                    3'b011: aluCtrl = aluSltu;
                    3'b100: aluCtrl = aluXor;
                    3'b101: aluCtrl = funct7Alt ? aluSra : aluSrl;
                    3'b110: aluCtrl = aluOr;
                    3'b111: aluCtrl = aluAnd;
                endcase
            end

            opIType: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (funct3)
                    3'b000: aluCtrl = aluAdd;
                    3'b001: aluCtrl = aluSll;
                    3'b010: aluCtrl = aluSlt;
                    3'b011: aluCtrl = aluSltu;
                    3'b100: aluCtrl = aluXor;
                    3'b101: aluCtrl = funct7Alt ? aluSra : aluSrl;
                    3'b110: aluCtrl = aluOr;
                    3'b111: aluCtrl = aluAnd;
                endcase
            end

            opLoad: begin
                aluSrc    = 1'b1;
                resultSel = 1'b1;
                regWrite  = 1'b1;
                memRead   = 1'b1;
            end

            opStore: begin
                immSel   = immS;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end

            opLui: begin
                immSel   = immU;
                aluCtrl  = aluPassB;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end

            opAuipc: begin
                immSel      = immU;
                aluSrc      = 1'b1;
                aluPcSelect = 1'b1;
                regWrite    = 1'b1;
            end

            opJal: begin
                immSel   = immJ;
                regWrite = 1'b1;
                jump     = 1'b1;
                pcSrc    = 1'b1;
            end

            // Target is rs1 plus the I immediate, formed by the ALU
            opJalr: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                jump     = 1'b1;
                jumpReg  = 1'b1;
                pcSrc    = 1'b1;
            end

            opBranch: begin
                immSel = immB;
                case (funct3)
                    3'b000:  pcSrc = zero;
                    3'b001:  pcSrc = !zero;
                    3'b100:  pcSrc = lessThan;
                    3'b101:  pcSrc = !lessThan;
                    3'b110:  pcSrc = lessThan;
                    3'b111:  pcSrc = !lessThan;
                    default: pcSrc = 1'b0;
                endcase
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- core/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   dDatR,
    input  logic          dAck,
    output logic          dCyc,
    output logic          dStb,
    output logic          dWe,
    output logic [31:0]   dAdr,
    output logic [31:0]   dDatW,
    output logic [31:0]   redirectPc,
    instrQueueIf.consumer take
);
    import rvPkg::*;

    instrWord        instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] regFile [32];
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] aluA;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic [xlen:0]   cmpDiff;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] writeData;

    logic [2:0] immSel;
    logic [3:0] aluCtrl;
    logic       aluSrc;
    logic       aluPcSelect;
    logic       resultSel;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       unsignedCmp;
    logic       jump;
    logic       jumpReg;
    logic       pcSrc;
    logic       zero;
    logic       lessThan;
    logic       memAccess;
    logic       startAccess;
    logic       retire;

    assign instr = take.instr;
    assign pc    = take.pc;
    assign rs1   = instr.rType.rs1;
    assign rs2   = instr.rType.rs2;
    assign rd    = instr.rType.rd;

    controlUnit decoder (
        .instr       (instr),
        .zero        (zero),
        .lessThan    (lessThan),
        .immSel      (immSel),
        .aluCtrl     (aluCtrl),
        .aluSrc      (aluSrc),
        .aluPcSelect (aluPcSelect),
        .resultSel   (resultSel),
        .regWrite    (regWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .unsignedCmp (unsignedCmp),
        .jump        (jump),
        .jumpReg     (jumpReg),
        .pcSrc       (pcSrc)
    );

    // x0 always reads as zero
    assign rs1Val = (rs1 == 5'd0) ? '0 : regFile[rs1];
    assign rs2Val = (rs2 == 5'd0) ? '0 : regFile[rs2];

    always_comb begin
        case (immSel)
            immI: imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            immS: imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            immB: imm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                         instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            immU: imm = {instr.uType.imm, 12'b0};
            immJ: imm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                         instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            default: imm = '0;
        endcase
    end

    assign aluA = aluPcSelect ? pc : rs1Val;
    assign aluB = aluSrc ? imm : rs2Val;

    always_comb begin
        case (aluCtrl)
            aluAdd:   aluResult = aluA + aluB;
            aluSub:   aluResult = aluA - aluB;
            aluXor:   aluResult = aluA ^ aluB;
            aluOr:    aluResult = aluA | aluB;
            aluAnd:   aluResult = aluA & aluB;
            aluSll:   aluResult = aluA << aluB[4:0];
            aluSrl:   aluResult = aluA >> aluB[4:0];
            aluSra:   aluResult = $signed(aluA) >>> aluB[4:0];
            aluSlt:   aluResult = {{(xlen - 1){1'b0}}, $signed(aluA) < $signed(aluB)};
            aluSltu:  aluResult = {{(xlen - 1){1'b0}}, aluA < aluB};
            aluPassB: aluResult = aluB;
            default:  aluResult = aluA + aluB;
        endcase
    end

    // Branch compare, one subtraction serves both signed and unsigned
    assign cmpDiff  = {1'b0, rs1Val} - {1'b0, rs2Val};
    assign zero     = (cmpDiff[xlen-1:0] == '0);
    assign lessThan = unsignedCmp ? cmpDiff[xlen] :
                      (rs1Val[xlen-1] != rs2Val[xlen-1]) ? rs1Val[xlen-1] : cmpDiff[xlen-1];

    assign pcPlus4    = pc + 32'd4;
    assign redirectPc = jumpReg ? {aluResult[xlen-1:1], 1'b0} : pc + imm;

    assign memAccess   = memRead || memWrite;
    assign startAccess = take.valid && memAccess && !dCyc;

    // Memory instructions wait at the head of the queue for dAck
    assign take.ready = !memAccess || (dCyc && dAck);
    assign retire     = take.valid && take.ready;
    assign take.flush = retire && pcSrc;

    assign writeData = jump ? pcPlus4 : (resultSel ? dDatR : aluResult);

    always_ff @(posedge clk) begin
        if (retire && regWrite && rd != 5'd0) begin
            regFile[rd] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dCyc <= 1'b0;
            dWe  <= 1'b0;
        end else if (startAccess) begin
            dCyc <= 1'b1;
            dWe  <= memWrite;
        end else if (dCyc && dAck) begin
            dCyc <= 1'b0;
            dWe  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (startAccess) begin
            dAdr  <= aluResult;
            dDatW <= rs2Val;
        end
    end

    assign dStb = dCyc;

endmodule

`default_nettype wire

//--- hdl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [31:0]   iDatR,
    input  logic          iAck,
    input  logic [31:0]   redirectPc,
    output logic          iCyc,
    output logic          iStb,
    output logic [31:0]   iAdr,
    instrQueueIf.producer push
);
    import rvPkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] fetchAdr;
    instrWord        fetched;
    logic            holding;
    // Read issued before a redirect, its data is unwanted
    logic            dropRead;
    logic            pushed;
    logic            readDone;
    logic            launch;

    assign pushed   = push.valid && push.ready && !push.flush;
    assign readDone = iCyc && iAck;
    // Next read goes out right after a push or whenever the unit is idle
    assign launch   = !push.flush && (pushed || (!iCyc && !holding));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= resetPc;
            iCyc     <= 1'b0;
            holding  <= 1'b0;
            dropRead <= 1'b0;
        end else if (push.flush) begin
            pc       <= redirectPc;
            holding  <= 1'b0;
            dropRead <= iCyc && !iAck;
            if (readDone) begin
                iCyc <= 1'b0;
            end
        end else begin
            if (readDone) begin
                iCyc     <= 1'b0;
                dropRead <= 1'b0;
                holding  <= !dropRead;
            end
            if (launch) begin
                iCyc <= 1'b1;
            end
            if (pushed) begin
                holding <= 1'b0;
                pc      <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            fetchAdr <= pushed ? pc + 32'd4 : pc;
        end
        if (readDone && !dropRead) begin
            fetched <= iDatR;
        end
    end

    assign iStb       = iCyc;
    assign iAdr       = fetchAdr;
    assign push.valid = holding;
    assign push.pc    = pc;
    assign push.instr = fetched;

endmodule

`default_nettype wire

//--- hdl/instrQueue.sv
`timescale 1ns/1ps
`default_nettype none

module instrQueue #(
    parameter int queueDepth = 4
) (
    input  logic          clk,
    input  logic          reset,
    instrQueueIf.queue    push,
    instrQueueIf.producer pop
);
    import rvPkg::*;

    localparam int ptrWidth = $clog2(queueDepth);
    localparam logic [ptrWidth:0] fullCount = (ptrWidth + 1)'(queueDepth);

    logic [xlen-1:0]     pcMem [queueDepth];
    instrWord            instrMem [queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0]   count;
    logic                pushEn;
    logic                popEn;

    // Fetch side sees the same flush as the consumer raised
    assign push.flush = pop.flush;
    assign push.ready = (count != fullCount);

    assign pop.valid = (count != '0);
    assign pop.pc    = pcMem[rdPtr];
    assign pop.instr = instrMem[rdPtr];

    assign pushEn = push.valid && push.ready && !pop.flush;
    assign popEn  = pop.valid && pop.ready && !pop.flush;

    always_ff @(posedge clk) begin
        if (reset || pop.flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushEn, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pushEn) begin
            pcMem[wrPtr]    <= push.pc;
            instrMem[wrPtr] <= push.instr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvDecoupledTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecoupledTop #(
    parameter int          queueDepth = 4,
    parameter logic [31:0] resetPc    = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    output logic        iCyc,
    output logic        iStb,
    output logic [31:0] iAdr,
    input  logic [31:0] iDatR,
    input  logic        iAck,
    output logic        dCyc,
    output logic        dStb,
    output logic        dWe,
    output logic [31:0] dAdr,
    output logic [31:0] dDatW,
    input  logic [31:0] dDatR,
    input  logic        dAck
);

    logic [31:0] redirectPc;

    instrQueueIf fetchToQueue ();
    instrQueueIf queueToExec ();

    fetchUnit #(
        .resetPc (resetPc)
    ) fetch (
        .clk        (clk),
        .reset      (reset),
        .iDatR      (iDatR),
        .iAck       (iAck),
        .redirectPc (redirectPc),
        .iCyc       (iCyc),
        .iStb       (iStb),
        .iAdr       (iAdr),
        .push       (fetchToQueue.producer)
    );

    // Also forwards the flush from the execute side back to fetch
    instrQueue #(
        .queueDepth (queueDepth)
    ) buffer (
        .clk   (clk),
        .reset (reset),
        .push  (fetchToQueue.queue),
        .pop   (queueToExec.producer)
    );

    execUnit exec (
        .clk        (clk),
        .reset      (reset),
        .dDatR      (dDatR),
        .dAck       (dAck),
        .dCyc       (dCyc),
        .dStb       (dStb),
        .dWe        (dWe),
        .dAdr       (dAdr),
        .dDatW      (dDatW),
        .redirectPc (redirectPc),
        .take       (queueToExec.consumer)
    );

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rvDecoupledTb \
    -f rvDecoupled.f -o simv \
    && ./obj_dir/simv \
    || exit 1

//--- rvDecoupled.f
common/rvPkg.sv
common/instrQueueIf.sv
hdl/fetchUnit.sv
hdl/instrQueue.sv
core/controlUnit.sv
core/execUnit.sv
hdl/rvDecoupledTop.sv
verification/rvDecoupled_properties.sv
verification/rvDecoupledTb.sv

//--- verification/rvDecoupledTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecoupledTb;

    localparam int numStores    = 24;
    localparam int watchdogTime = (3 + 64 * 10) * 100;

    logic        clk;
    logic        reset;
    logic        iCyc;
    logic        iStb;
    logic [31:0] iAdr;
    logic [31:0] iDatR;
    logic        iAck;
    logic        dCyc;
    logic        dStb;
    logic        dWe;
    logic [31:0] dAdr;
    logic [31:0] dDatW;
    logic [31:0] dDatR;
    logic        dAck;

    logic [31:0] rom [64];
    logic [31:0] ram [128];
    logic [31:0] expAdr [numStores];
    logic [31:0] expDat [numStores];
    int          romFill;
    int          expFill;
    int          storeIdx;
    int          iWait;
    int          dWait;
    logic        iBusy;
    logic        dBusy;
    logic        allStored;

    rvDecoupledTop #(
        .queueDepth (4),
        .resetPc    (32'h0)
    ) dut (
        .clk   (clk),
        .reset (reset),
        .iCyc  (iCyc),
        .iStb  (iStb),
        .iAdr  (iAdr),
        .iDatR (iDatR),
        .iAck  (iAck),
        .dCyc  (dCyc),
        .dStb  (dStb),
        .dWe   (dWe),
        .dAdr  (dAdr),
        .dDatW (dDatW),
        .dDatR (dDatR),
        .dAck  (dAck)
    );

    always #50 clk = ~clk;

    // RV32I encoders
    function automatic logic [31:0] rEnc(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iEnc(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sEnc(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bEnc(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uEnc(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jEnc(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic emit(input logic [31:0] word);
        rom[romFill] = word;
        romFill++;
    endtask

    task automatic addExpected(input logic [31:0] adr, input logic [31:0] dat);
        expAdr[expFill] = adr;
        expDat[expFill] = dat;
        expFill++;
    endtask

    // Taken branch skips a bad store while the not-taken one reaches its marker
    task automatic branchPair(input logic [2:0] f3, input logic [4:0] tRs1,
                              input logic [4:0] tRs2, input logic [4:0] nRs1,
                              input logic [4:0] nRs2, input logic [11:0] markerAdr);
        emit(bEnc(13'd8, tRs2, tRs1, f3));
        emit(sEnc(12'h0FC, 5'd1, 5'd0));
        emit(bEnc(13'd8, nRs2, nRs1, f3));
        emit(sEnc(markerAdr, 5'd2, 5'd0));
    endtask

    task automatic loadProgram;
        emit(iEnc(12'hFF8, 5'd0, 3'd0, 5'd1, 7'h13));
        emit(iEnc(12'd3, 5'd0, 3'd0, 5'd2, 7'h13));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd0, 5'd10));
        emit(sEnc(12'h000, 5'd10, 5'd0));
        emit(rEnc(7'h20, 5'd2, 5'd1, 3'd0, 5'd10));
        emit(sEnc(12'h004, 5'd10, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd4, 5'd10));
        emit(sEnc(12'h008, 5'd10, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd6, 5'd10));
        emit(sEnc(12'h00C, 5'd10, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd7, 5'd10));
        emit(sEnc(12'h010, 5'd10, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd1, 5'd10));
        emit(sEnc(12'h014, 5'd10, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd5, 5'd10));
        emit(sEnc(12'h018, 5'd10, 5'd0));
        emit(rEnc(7'h20, 5'd2, 5'd1, 3'd5, 5'd10));
        emit(sEnc(12'h01C, 5'd10, 5'd0));
        // x11 keeps the slt result for the final store
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd2, 5'd11));
        emit(sEnc(12'h020, 5'd11, 5'd0));
        emit(rEnc(7'h00, 5'd2, 5'd1, 3'd3, 5'd10));
        emit(sEnc(12'h024, 5'd10, 5'd0));
        emit(iEnc(12'h401, 5'd1, 3'd5, 5'd10, 7'h13));
        emit(sEnc(12'h028, 5'd10, 5'd0));
        emit(iEnc(12'hFFF, 5'd2, 3'd3, 5'd10, 7'h13));
        emit(sEnc(12'h02C, 5'd10, 5'd0));
        emit(uEnc(20'h12345, 5'd10, 7'h37));
        emit(sEnc(12'h030, 5'd10, 5'd0));
        emit(uEnc(20'h00001, 5'd10, 7'h17));
        emit(sEnc(12'h034, 5'd10, 5'd0));
        branchPair(3'd0, 5'd2, 5'd2, 5'd1, 5'd2, 12'h038);
        branchPair(3'd1, 5'd1, 5'd2, 5'd2, 5'd2, 12'h03C);
        branchPair(3'd4, 5'd1, 5'd2, 5'd2, 5'd1, 12'h040);
        branchPair(3'd5, 5'd2, 5'd1, 5'd1, 5'd2, 12'h044);
        branchPair(3'd6, 5'd2, 5'd1, 5'd1, 5'd2, 12'h048);
        branchPair(3'd7, 5'd1, 5'd2, 5'd2, 5'd1, 12'h04C);
        emit(jEnc(21'd8, 5'd5));
        emit(sEnc(12'h0FC, 5'd1, 5'd0));
        emit(sEnc(12'h050, 5'd5, 5'd0));
        // Odd offset so the JALR target needs bit 0 cleared
        emit(iEnc(12'd17, 5'd5, 3'd0, 5'd7, 7'h67));
        emit(sEnc(12'h0FC, 5'd1, 5'd0));
        emit(sEnc(12'h054, 5'd7, 5'd0));
        emit(iEnc(12'd0, 5'd0, 3'd2, 5'd8, 7'h03));
        emit(iEnc(12'd1, 5'd8, 3'd0, 5'd8, 7'h13));
        emit(sEnc(12'h058, 5'd8, 5'd0));
        emit(sEnc(12'h100, 5'd11, 5'd0));
    endtask

    task automatic loadExpected;
        addExpected(32'h00, 32'hFFFFFFFB);
        addExpected(32'h04, 32'hFFFFFFF5);
        addExpected(32'h08, 32'hFFFFFFFB);
        addExpected(32'h0C, 32'hFFFFFFFB);
        addExpected(32'h10, 32'h00000000);
        addExpected(32'h14, 32'hFFFFFFC0);
        addExpected(32'h18, 32'h1FFFFFFF);
        addExpected(32'h1C, 32'hFFFFFFFF);
        addExpected(32'h20, 32'h00000001);
        addExpected(32'h24, 32'h00000000);
        addExpected(32'h28, 32'hFFFFFFFC);
        addExpected(32'h2C, 32'h00000001);
        addExpected(32'h30, 32'h12345000);
        addExpected(32'h34, 32'h00001070);
        addExpected(32'h38, 32'h00000003);
        addExpected(32'h3C, 32'h00000003);
        addExpected(32'h40, 32'h00000003);
        addExpected(32'h44, 32'h00000003);
        addExpected(32'h48, 32'h00000003);
        addExpected(32'h4C, 32'h00000003);
        addExpected(32'h50, 32'h000000DC);
        addExpected(32'h54, 32'h000000E8);
        addExpected(32'h58, 32'hFFFFFFFC);
        addExpected(32'h100, 32'h00000001);
    endtask

    initial begin
        void'($urandom(32'h98cd4279));
        clk       = 1'b0;
        reset     = 1'b1;
        iDatR     = '0;
        iAck      = 1'b0;
        dDatR     = '0;
        dAck      = 1'b0;
        romFill   = 0;
        expFill   = 0;
        storeIdx  = 0;
        iBusy     = 1'b0;
        dBusy     = 1'b0;
        allStored = 1'b0;
        for (int i = 0; i < 128; i++) begin
            ram[i] = 32'h5A000000 ^ (i * 4);
        end
        loadProgram();
        loadExpected();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        wait (allStored);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(watchdogTime);
        failRun("Timeout: the program never stored 1 to address 'h100");
    end

    // Instruction ROM slave
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (iAck) begin
                iAck  = 1'b0;
                iBusy = 1'b0;
            end else if (!reset && iCyc && iStb) begin
                if (!iBusy) begin
                    iBusy = 1'b1;
                    iWait = $urandom_range(3, 0);
                    assert (iAdr[1:0] == 2'b00)
                        else failRun($sformatf("Misaligned instruction fetch from %h at %0t",
                                               iAdr, $time));
                end
                if (iWait == 0) begin
                    iDatR = rom[iAdr[7:2]];
                    iAck  = 1'b1;
                end else begin
                    iWait--;
                end
            end
        end
    end

    // Data RAM slave checks every store as it is acked
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (dAck) begin
                dAck  = 1'b0;
                dBusy = 1'b0;
            end else if (!reset && dCyc && dStb) begin
                if (!dBusy) begin
                    dBusy = 1'b1;
                    dWait = $urandom_range(3, 0);
                end
                if (dWait != 0) begin
                    dWait--;
                end else if (!dWe) begin
                    dDatR = ram[dAdr[8:2]];
                    dAck  = 1'b1;
                end else begin
                    assert (dAdr == expAdr[storeIdx])
                        else failRun($sformatf("MISMATCH time=%0t dAdr expected=%h got=%h",
                                               $time, expAdr[storeIdx], dAdr));
                    assert (dDatW == expDat[storeIdx])
                        else failRun($sformatf("MISMATCH time=%0t dDatW expected=%h got=%h",
                                               $time, expDat[storeIdx], dDatW));
                    ram[dAdr[8:2]] = dDatW;
                    dAck           = 1'b1;
                    storeIdx++;
                    if (dAdr == 32'h100) begin
                        allStored = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/rvDecoupled_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rvDecoupled_properties (
    input logic        clk,
    input logic        reset,
    input logic        iCyc,
    input logic        iStb,
    input logic [31:0] iAdr,
    input logic        iAck,
    input logic        dCyc,
    input logic        dStb,
    input logic        dWe,
    input logic [31:0] dAdr,
    input logic [31:0] dDatW,
    input logic        dAck
);

    // Both buses idle once reset has been seen
    assert property (@(posedge clk) reset |=> (!iCyc && !iStb && !dCyc && !dStb && !dWe))
        else $error("Wishbone strobes not low after reset");

    assert property (@(posedge clk) disable iff (reset) iStb |-> iCyc)
        else $error("iStb high without iCyc");

    assert property (@(posedge clk) disable iff (reset)
        (iCyc && !iAck) |=> (iCyc && $stable(iAdr)))
        else $error("Instruction cycle dropped or iAdr changed before iAck");

    assert property (@(posedge clk) disable iff (reset) dStb |-> dCyc)
        else $error("dStb high without dCyc");

    // Address, direction and write data held for the whole cycle
    assert property (@(posedge clk) disable iff (reset)
        (dCyc && !dAck) |=> (dCyc && $stable(dAdr) && $stable(dWe) && $stable(dDatW)))
        else $error("Data cycle signals changed before dAck");

endmodule

bind rvDecoupledTop rvDecoupled_properties props (
    .clk   (clk),
    .reset (reset),
    .iCyc  (iCyc),
    .iStb  (iStb),
    .iAdr  (iAdr),
    .iAck  (iAck),
    .dCyc  (dCyc),
    .dStb  (dStb),
    .dWe   (dWe),
    .dAdr  (dAdr),
    .dDatW (dDatW),
    .dAck  (dAck)
);

`default_nettype wire
